/* source/video_pkg.sv */
// video path definitions for the colour mixer
// widths of the pixel inputs, palette geometry and the layer choice

package video_pkg;

    // palette index, 4096 entries
    parameter int pal_aw = 12;

    // palette word, 15-bit colour plus shadow-immune bit
    parameter int pal_dw = 16;

    // one colour component
    parameter int comp_w = 5;

    // tile mapper address
    parameter int tmap_w = 11;

    // object layer pixel from the sprite engine
    parameter int obj_w = 12;

    // which layer feeds the palette for one pixel
    typedef enum logic {
        layer_tile,
        layer_road
    } layer_e;

endpackage

/* source/bus_pkg.sv */
// AXI4-Lite definitions for the palette CPU port
// widths, response codes and channel state encodings

package bus_pkg;

    // byte address, word index sits in bits 13:2
    parameter int axi_aw = 14;
    parameter int axi_dw = 32;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // write channel: aw and w taken together, then b
    typedef enum logic {
        wr_idle,
        wr_resp
    } wr_state_e;

    // read channel: ar, one ram cycle, then r
    typedef enum logic [1:0] {
        rd_idle,
        rd_wait,
        rd_data
    } rd_state_e;

endpackage

/* source/layer_select.sv */
// road / tile layer select
// decides per pixel whether the road generator or the tile mapper
// supplies the palette address, remaps the road colour and registers
// the address together with the sprite shadow flag

`timescale 1ns/1ps

module layer_select (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic [video_pkg::tmap_w-1:0] tmap_addr,
    input  logic [video_pkg::obj_w-1:0]  obj_pxl,
    input  logic [7:0]                  rd_pxl,
    // rc bits 4:3 of the road control
    input  logic [1:0]                  rc,
    input  logic                        sa,
    input  logic                        sb,
    input  logic                        fix,
    input  logic                        shadow,
    output logic [video_pkg::pal_aw-1:0] pal_addr,
    output logic                        shadow_q
);
    import video_pkg::*;

    layer_e              layer_sel;
    logic [tmap_w-1:0]   road_addr;
    logic [pal_aw-1:0]   next_addr;

    // priority equations, fixed layer always wins
    always_comb begin
        layer_sel = layer_tile;
        if (!fix) begin
            // transparent object pixel lets the road through
            if (obj_pxl[3:0] == 4'h0 && (!rc[0] || (!sa && !sb))) begin
                layer_sel = layer_road;
            end
            // special object code drawn behind the road
            if (obj_pxl[11:10] == 2'b10 && obj_pxl[3:0] == 4'b0101) begin
                layer_sel = layer_road;
            end
        end
    end

    // road colour remap
    always_comb begin
        road_addr[3:0] = rd_pxl[3:0];
        case (rc)
            2'd0, 2'd1: road_addr[5:4] = 2'b11;
            2'd2:       road_addr[5:4] = {1'b0, rd_pxl[4]};
            default:    road_addr[5:4] = rd_pxl[5:4];
        endcase
        // upper bank follows rc bit 4
        road_addr[10:6] = {5{rc[1]}};
    end

    // top palette bit never set by either layer
    assign next_addr = {1'b0, (layer_sel == layer_road) ? road_addr : tmap_addr};

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_addr <= '0;
            shadow_q <= 1'b0;
        end else if (pxl_cen) begin
            pal_addr <= next_addr;
            // shadow kept in step with the address
            shadow_q <= shadow;
        end
    end

endmodule

/* source/blank_delay.sv */
// blanking delay line
// moves horizontal and vertical blanking through a pixel-timed shift
// register so they line up with the colour leaving the mixer

`timescale 1ns/1ps

module blank_delay #(
    parameter int BLANK_DLY = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    input  logic pre_lhbl,
    input  logic pre_lvbl,
    output logic lhbl,
    output logic lvbl
);

    logic [BLANK_DLY-1:0] hbl_sr;
    logic [BLANK_DLY-1:0] vbl_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            // all zeros, output starts blanked
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (pxl_cen) begin
            hbl_sr[0] <= pre_lhbl;
            vbl_sr[0] <= pre_lvbl;
            for (int i = 1; i < BLANK_DLY; i++) begin
                hbl_sr[i] <= hbl_sr[i-1];
                vbl_sr[i] <= vbl_sr[i-1];
            end
        end
    end

    // last stage drives the outputs
    assign lhbl = hbl_sr[BLANK_DLY-1];
    assign lvbl = vbl_sr[BLANK_DLY-1];

endmodule

/* source/palette_ram.sv */
// palette memory
// 4096 x 16 dual-port ram, byte writable
// port a belongs to the cpu through an AXI4-Lite slave,
// port b is read every clock by the video path

`timescale 1ns/1ps

module palette_ram (
    input  logic                         clk,
    input  logic                         rst,
    // AXI4-Lite slave
    input  logic [bus_pkg::axi_aw-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [bus_pkg::axi_dw-1:0]   wdata,
    input  logic [bus_pkg::axi_dw/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic                         bvalid,
    output logic [1:0]                   bresp,
    input  logic                         bready,
    input  logic [bus_pkg::axi_aw-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic                         rvalid,
    output logic [bus_pkg::axi_dw-1:0]   rdata,
    output logic [1:0]                   rresp,
    input  logic                         rready,
    // video read port
    input  logic [video_pkg::pal_aw-1:0] pal_addr,
    output logic [video_pkg::pal_dw-1:0] pal_word
);
    import video_pkg::*;
    import bus_pkg::*;

    logic [pal_dw-1:0] mem [2**pal_aw];

    wr_state_e         wr_state;
    rd_state_e         rd_state;
    logic              wr_go;
    logic              ar_go;
    logic [pal_aw-1:0] wr_idx;
    logic [pal_aw-1:0] rd_addr;
    logic [pal_dw-1:0] rd_word;

    // write takes aw and w in the same cycle
    assign wr_go   = (wr_state == wr_idle) && awvalid && wvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign wr_idx  = awaddr[pal_aw+1:2];
    assign bvalid  = (wr_state == wr_resp);
    assign bresp   = resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (wr_go) wr_state <= wr_resp;
                default: if (bready) wr_state <= wr_idle;
            endcase
        end
    end

    // read: capture address, one ram cycle, then hold data
    assign arready = (rd_state == rd_idle);
    assign ar_go   = arready && arvalid;
    assign rvalid  = (rd_state == rd_data);
    assign rresp   = resp_okay;
    assign rdata   = {{(axi_dw-pal_dw){1'b0}}, rd_word};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (ar_go) rd_state <= rd_wait;
                rd_wait: rd_state <= rd_data;
                default: if (rready) rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_go) begin
            rd_addr <= araddr[pal_aw+1:2];
        end
    end

    // port a, cpu side
    always_ff @(posedge clk) begin
        if (wr_go) begin
            // lane 0 low byte, lane 1 high byte
            if (wstrb[0]) mem[wr_idx][7:0] <= wdata[7:0];
            if (wstrb[1]) mem[wr_idx][15:8] <= wdata[15:8];
        end
        // read only once, so rdata stays put while r is stalled
        if (rd_state == rd_wait) begin
            rd_word <= mem[rd_addr];
        end
    end

    // port b, video side, never stalls
    always_ff @(posedge clk) begin
        pal_word <= mem[pal_addr];
    end

endmodule

/* source/rgb_output.sv */
// colour output stage
// splits the palette word into 5-bit red, green and blue, darkens it
// under sprite shadow and forces black while blanked

`timescale 1ns/1ps

module rgb_output (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic [video_pkg::pal_dw-1:0] pal_word,
    input  logic                         shadow_q,
    // already delayed blanking
    input  logic                         lhbl,
    input  logic                         lvbl,
    output logic [video_pkg::comp_w-1:0] red,
    output logic [video_pkg::comp_w-1:0] green,
    output logic [video_pkg::comp_w-1:0] blue
);
    import video_pkg::*;

    logic [comp_w-1:0] r_raw;
    logic [comp_w-1:0] g_raw;
    logic [comp_w-1:0] b_raw;
    logic              dim_en;

    // roughly 3/4 brightness
    function automatic logic [comp_w-1:0] dim(input logic [comp_w-1:0] c);
        return c - (c >> 2);
    endfunction

    // nibble plus shared low bit from the top of the word
    assign r_raw = {pal_word[3:0], pal_word[12]};
    assign g_raw = {pal_word[7:4], pal_word[13]};
    assign b_raw = {pal_word[11:8], pal_word[14]};

    // bit 15 marks colours that ignore shadow
    assign dim_en = shadow_q && !pal_word[15];

    always_ff @(posedge clk) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (lhbl && lvbl) begin
                red   <= dim_en ? dim(r_raw) : r_raw;
                green <= dim_en ? dim(g_raw) : g_raw;
                blue  <= dim_en ? dim(b_raw) : b_raw;
            end else begin
                // black during blanking
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

/* source/colmix_top.sv */
// colour mixer top level
// layer select and blank delay run side by side, the palette ram
// serves both video and the cpu, rgb output makes the final colour

`timescale 1ns/1ps

module colmix_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    // cpu palette access
    input  logic [bus_pkg::axi_aw-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [bus_pkg::axi_dw-1:0]   wdata,
    input  logic [bus_pkg::axi_dw/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic                         bvalid,
    output logic [1:0]                   bresp,
    input  logic                         bready,
    input  logic [bus_pkg::axi_aw-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic                         rvalid,
    output logic [bus_pkg::axi_dw-1:0]   rdata,
    output logic [1:0]                   rresp,
    input  logic                         rready,
    // layer inputs
    input  logic [video_pkg::tmap_w-1:0] tmap_addr,
    input  logic [video_pkg::obj_w-1:0]  obj_pxl,
    input  logic [7:0]                   rd_pxl,
    input  logic [1:0]                   rc,
    input  logic                         sa,
    input  logic                         sb,
    input  logic                         fix,
    input  logic                         shadow,
    input  logic                         pre_lhbl,
    input  logic                         pre_lvbl,
    // video out
    output logic [video_pkg::comp_w-1:0] red,
    output logic [video_pkg::comp_w-1:0] green,
    output logic [video_pkg::comp_w-1:0] blue,
    output logic                         lhbl,
    output logic                         lvbl
);
    import video_pkg::*;

    logic [pal_aw-1:0] pal_addr;
    logic [pal_dw-1:0] pal_word;
    logic              shadow_q;

    layer_select i_layer_select (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tmap_addr (tmap_addr),
        .obj_pxl   (obj_pxl),
        .rd_pxl    (rd_pxl),
        .rc        (rc),
        .sa        (sa),
        .sb        (sb),
        .fix       (fix),
        .shadow    (shadow),
        .pal_addr  (pal_addr),
        .shadow_q  (shadow_q)
    );

    // two ticks to match the address register plus ram read
    blank_delay #(
        .BLANK_DLY (2)
    ) i_blank_delay (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

    palette_ram i_palette_ram (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rresp    (rresp),
        .rready   (rready),
        .pal_addr (pal_addr),
        .pal_word (pal_word)
    );

    rgb_output i_rgb_output (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pal_word (pal_word),
        .shadow_q (shadow_q),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

/* testbench/colmix_tb.sv */
// colour mixer testbench
// fills the palette over AXI4-Lite, reads it back, then runs the
// pixel path through tile, road, shadow and blanking phases against
// a reference model built from the layer and colour rules

`timescale 1ns/1ps

module colmix_tb;
    import video_pkg::*;
    import bus_pkg::*;

    // roughly twice the length of all phases together
    localparam int CYCLE_LIMIT = 3000;

    logic clk = 1'b0;
    logic pxl_cen = 1'b0;
    logic rst;
    logic [axi_aw-1:0] awaddr;
    logic awvalid, awready;
    logic [axi_dw-1:0] wdata;
    logic [axi_dw/8-1:0] wstrb;
    logic wvalid, wready;
    logic bvalid, bready;
    logic [1:0] bresp;
    logic [axi_aw-1:0] araddr;
    logic arvalid, arready;
    logic rvalid, rready;
    logic [axi_dw-1:0] rdata;
    logic [1:0] rresp;
    logic [tmap_w-1:0] tmap_addr;
    logic [obj_w-1:0] obj_pxl;
    logic [7:0] rd_pxl;
    logic [1:0] rc;
    logic sa, sb, fix, shadow, pre_lhbl, pre_lvbl;
    logic [comp_w-1:0] red, green, blue;
    logic lhbl, lvbl;

    // reference state
    logic [pal_dw-1:0] pal_model [2**pal_aw];
    logic [pal_dw-1:0] exp_rd;
    logic [14:0] col_pend, col_out;
    logic [1:0] blk_pend, blk_out;
    logic r_stalled = 1'b0;
    logic [31:0] lcg_state = 32'd36213;
    int cycles = 0;

    colmix_top i_colmix_top (.*);

    always #10 clk = ~clk;

    // one pixel every other clock
    always @(posedge clk) pxl_cen <= rst ? 1'b0 : ~pxl_cen;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the 128 entries in use are the low 64 plus the 0x7c0 bank
    function automatic logic [11:0] entry_index(input logic [6:0] k);
        return k[6] ? {6'b011111, k[5:0]} : {6'b000000, k[5:0]};
    endfunction

    function automatic logic road_wins(input logic [11:0] obj, input logic [1:0] rc_v,
                                       input logic sa_v, input logic sb_v,
                                       input logic fix_v);
        logic see_through;
        logic behind;
        see_through = (obj[3:0] == 4'h0) && (rc_v[0] == 1'b0 || (sa_v | sb_v) == 1'b0);
        behind = (obj[11:10] == 2'b10) && (obj[3:0] == 4'b0101);
        return !fix_v && (see_through || behind);
    endfunction

    function automatic logic [11:0] road_index(input logic [7:0] rd, input logic [1:0] rc_v);
        logic [1:0] mid;
        if (rc_v == 2'd2)
            mid = {1'b0, rd[4]};
        else if (rc_v == 2'd3)
            mid = rd[5:4];
        else
            mid = 2'b11;
        return {1'b0, {5{rc_v[1]}}, mid, rd[3:0]};
    endfunction

    // unpack plus optional dimming to c minus c/4
    function automatic logic [14:0] colour_of(input logic [15:0] w, input logic shade);
        logic [4:0] r_c, g_c, b_c;
        r_c = {w[3:0], w[12]};
        g_c = {w[7:4], w[13]};
        b_c = {w[11:8], w[14]};
        if (shade && !w[15]) begin
            r_c = r_c - r_c / 5'd4;
            g_c = g_c - g_c / 5'd4;
            b_c = b_c - b_c / 5'd4;
        end
        return {r_c, g_c, b_c};
    endfunction

    function automatic logic [14:0] predict_colour();
        logic [11:0] idx;
        if (road_wins(obj_pxl, rc, sa, sb, fix))
            idx = road_index(rd_pxl, rc);
        else
            idx = {1'b0, tmap_addr};
        return colour_of(pal_model[idx], shadow);
    endfunction

    task automatic abort_run(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // two ticks of latency with the colour gated by the already delayed blanking
    always @(posedge clk) begin
        if (rst) begin
            col_pend <= '0;
            col_out <= '0;
            blk_pend <= '0;
            blk_out <= '0;
        end else if (pxl_cen) begin
            col_out <= (blk_out == 2'b11) ? col_pend : 15'd0;
            col_pend <= predict_colour();
            blk_out <= blk_pend;
            blk_pend <= {pre_lhbl, pre_lvbl};
        end
    end

    always @(posedge clk) r_stalled <= !rst && rvalid && !rready;

    colour_check: assert property (@(posedge clk) disable iff (rst)
        {red, green, blue} == col_out)
        else abort_run("rgb output differs from model");
    blank_check: assert property (@(posedge clk) disable iff (rst)
        {lhbl, lvbl} == blk_out)
        else abort_run("delayed blanking differs from model");
    aw_w_check: assert property (@(posedge clk) disable iff (rst)
        awready == wready && (!awready || (awvalid && wvalid)))
        else abort_run("aw and w not accepted together");
    bresp_check: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == resp_okay)
        else abort_run("bresp not okay");
    rdata_check: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rdata == {16'h0000, exp_rd} && rresp == resp_okay)
        else abort_run("rdata or rresp differs from model");
    rhold_check: assert property (@(posedge clk) disable iff (rst)
        r_stalled |-> rvalid)
        else abort_run("rvalid dropped while rready low");

    task automatic write_entry(input logic [11:0] idx, input logic [15:0] data,
                               input logic [3:0] strb);
        logic [31:0] junk;
        junk = next_rand();
        @(posedge clk);
        awaddr <= {idx, 2'b00};
        // upper half of wdata must be ignored
        wdata <= {junk[15:0], data};
        wstrb <= strb;
        // often one channel comes up a cycle before the other
        awvalid <= junk[31] || !junk[30];
        wvalid <= junk[31] || junk[30];
        bready <= 1'b1;
        if (!junk[31]) begin
            @(posedge clk);
            awvalid <= 1'b1;
            wvalid <= 1'b1;
        end
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (strb[0]) pal_model[idx][7:0] = data[7:0];
        if (strb[1]) pal_model[idx][15:8] = data[15:8];
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic read_entry(input logic [11:0] idx, input int stall);
        @(posedge clk);
        araddr <= {idx, 2'b00};
        arvalid <= 1'b1;
        rready <= 1'b0;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        exp_rd <= pal_model[idx];
        do @(posedge clk); while (!rvalid);
        // r held back so rvalid and rdata have to stay
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // modes are tile (0), road (1), shadow on tiles (2) and road with random blanking (3)
    task automatic drive_pixel(input int mode);
        logic [31:0] r;
        logic [31:0] s;
        logic [11:0] t;
        r = next_rand();
        s = next_rand();
        t = entry_index(r[6:0]);
        tmap_addr <= t[10:0];
        rd_pxl <= r[15:8];
        rc <= r[17:16];
        sa <= r[18];
        sb <= r[19];
        fix <= (mode == 0) || (mode == 2) || (r[22:20] == 3'd0);
        // see-through and behind-road codes come up often
        case (s[1:0])
            2'd0: obj_pxl <= {s[13:6], 4'h0};
            2'd1: obj_pxl <= {2'b10, s[11:6], 4'b0101};
            default: obj_pxl <= s[13:2];
        endcase
        shadow <= (mode >= 2) ? s[20] : 1'b0;
        pre_lhbl <= (mode != 3) || (s[23:22] != 2'd0);
        pre_lvbl <= (mode != 3) || (s[25:24] != 2'd0);
    endtask

    task automatic run_pixels(input int ticks, input int mode);
        repeat (2 * ticks) begin
            @(posedge clk);
            drive_pixel(mode);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] r;
        logic [11:0] part_idx [32];
        // bus idle and video blanked on tile 0
        rst <= 1'b1;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        tmap_addr <= '0;
        obj_pxl <= '0;
        rd_pxl <= '0;
        rc <= '0;
        sa <= 1'b0;
        sb <= 1'b0;
        fix <= 1'b1;
        shadow <= 1'b0;
        pre_lhbl <= 1'b0;
        pre_lvbl <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        assert (!bvalid && !rvalid)
            else abort_run("bvalid or rvalid high after reset");

        // every entry the video path can reach gets a full word
        for (int k = 0; k < 128; k++) begin
            r = next_rand();
            write_entry(entry_index(k[6:0]), r[15:0], 4'hf);
        end
        // all 16 strobe patterns twice over
        for (int k = 0; k < 32; k++) begin
            r = next_rand();
            part_idx[k] = entry_index(r[6:0]);
            write_entry(part_idx[k], r[31:16], k[3:0]);
        end
        for (int k = 0; k < 32; k++) begin
            read_entry(part_idx[k], k % 4);
        end

        run_pixels(80, 0);
        run_pixels(200, 1);
        run_pixels(80, 2);
        run_pixels(100, 3);
        // let the last pixels drain through
        run_pixels(10, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* colmix.f */
source/video_pkg.sv
source/bus_pkg.sv
source/layer_select.sv
source/blank_delay.sv
source/palette_ram.sv
source/rgb_output.sv
source/colmix_top.sv
testbench/colmix_tb.sv

/* Makefile */
# colour mixer, Verilator lint and simulation

TOP = colmix_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f colmix.f

# the run passes only if the log holds the pass line
sim:
	verilator --binary --assert --top-module $(TOP) -f colmix.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
